//--- build.f
verilog/uart_frame_pkg.sv
verilog/uart_cmd_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_cmd_bridge.sv
bench/tb_clk_gen.sv
bench/uart_periph_model.sv
bench/tb_uart_cmd_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_cmd_bridge
FILELIST   := build.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_uart_cmd_bridge.sv
`timescale 1ns/10ps

module tb_uart_cmd_bridge;

  localparam int CPB     = 16;
  localparam int GAP     = 16;
  localparam int RX_TO   = 64;
  localparam int N_CMDS  = 150;
  localparam int LIMIT   =
    N_CMDS * (3 * uart_frame_pkg::FRAME_BITS + GAP + RX_TO) * CPB * 11 / 10;

  logic                  clk;
  logic                  rst_n;
  logic [15:0]           cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic [7:0]            read_data;
  logic [1:0]            read_status;
  logic                  read_vld;
  logic                  knob_vld;
  uart_frame_pkg::byte_t knob_data;
  logic [15:0]           knob_delay;
  logic [1:0]            knob_fault;
  logic                  byte_vld;
  uart_frame_pkg::byte_t byte_data;
  logic                  byte_ok;
  int                    gap_clks;

  uart_cmd_pkg::cmd_t    pend_q[$];
  uart_frame_pkg::byte_t exp_tx_q[$];
  logic [9:0]            exp_rd_q[$]; // {status, data} per expected read result.
  int                    val_errs = 0;
  int                    other_errs = 0;
  int                    cycles = 0;
  int                    frames_seen = 0;
  int                    reads_seen = 0;
  int                    exp_frames = 0;
  int                    exp_reads = 0;
  logic                  rdy_prev = 1'b1;
  logic                  in_lo = 1'b0;
  uart_frame_pkg::byte_t last_hi;
  uart_frame_pkg::byte_t last_lo;

  tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge #(
    .CLKS_PER_BIT    (CPB),
    .GAP_BITS        (GAP),
    .RX_TIMEOUT_BITS (RX_TO)
  ) dut (
    .clk(clk), .rst_n(rst_n), .cmd_in(cmd_in), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy),
    .rx(rx), .tx(tx), .read_data(read_data), .read_status(read_status), .read_vld(read_vld)
  );

  uart_periph_model #(.CLKS_PER_BIT(CPB)) periph (
    .clk(clk), .rst_n(rst_n), .tx(tx), .rx(rx), .knob_vld(knob_vld),
    .knob_data(knob_data), .knob_delay(knob_delay), .knob_fault(knob_fault),
    .byte_vld(byte_vld), .byte_data(byte_data), .byte_ok(byte_ok), .gap_clks(gap_clks)
  );

  task automatic check_byte(input string name, input uart_frame_pkg::byte_t exp,
                            input uart_frame_pkg::byte_t got);
    if (exp !== got)
    begin
      $display("Fail %s: expected %h, got %h", name, exp, got);
      val_errs++;
    end
  endtask

  task automatic check_status(input uart_cmd_pkg::rd_status_e exp,
                              input uart_cmd_pkg::rd_status_e got);
    if (exp !== got)
    begin
      $display("Fail read_status: expected %h, got %h", exp, got);
      val_errs++;
    end
  endtask

  task automatic check_cmd_done(input uart_cmd_pkg::cmd_t exp, input uart_cmd_pkg::cmd_t got);
    if (exp !== got)
    begin
      $display("Fail cmd_done: expected %h, got %h", exp, got);
      val_errs++;
    end
  endtask

  task automatic report_other(input string what);
    $display("%s at cycle %0d", what, cycles);
    other_errs++;
  endtask

  // drives commands with random idle stretches and often holds them through busy periods.
  initial
  begin
    logic [31:0]        rnd;
    uart_cmd_pkg::cmd_t c;
    logic [1:0]         f;
    void'($urandom(32'h55a0_70b4));
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    knob_vld = 1'b0;
    knob_data  = '0;
    knob_delay = '0;
    knob_fault = '0;
    wait (rst_n);
    @(posedge clk);
    if (!tx || !cmd_rdy || read_vld)
    begin
      $display("Fail tx/cmd_rdy/read_vld after reset: expected 1/1/0, got %h/%h/%h",
               tx, cmd_rdy, read_vld);
      val_errs++;
    end
    for (int i = 0; i < N_CMDS; i++)
    begin
      rnd = $urandom();
      c   = rnd[15:0];
      if (!cmd_vld)
        repeat ($urandom_range(0, 40)) @(posedge clk);
      cmd_in  <= c;
      cmd_vld <= 1'b1;
      @(posedge clk);
      while (!(cmd_vld && cmd_rdy))
        @(posedge clk);
      pend_q.push_back(c);
      exp_tx_q.push_back({c.wr, c.addr});
      exp_frames++;
      if (c.wr)
      begin
        exp_tx_q.push_back(c.data);
        exp_frames++;
      end
      else
      begin
        exp_reads++;
        rnd = $urandom();
        f   = (rnd[2:0] < 3'd5) ? 2'd0 : 2'(rnd[2:0] - 3'd4);
        knob_vld   <= 1'b1;
        knob_data  <= rnd[15:8];
        knob_delay <= 16'($urandom_range(0, 600));
        knob_fault <= f;
        if (f == 2'd3)
          exp_rd_q.push_back({2'(uart_cmd_pkg::RD_TIMEOUT), 8'h00});
        else
          exp_rd_q.push_back({f, rnd[15:8]});
      end
      if ($urandom_range(0, 1) == 0)
        cmd_vld <= 1'b0;
      @(posedge clk);
      knob_vld <= 1'b0;
    end
    cmd_vld <= 1'b0;
    while (pend_q.size() > 0)
      @(posedge clk);
    repeat (4 * CPB) @(posedge clk);
    if (exp_tx_q.size() != 0 || exp_rd_q.size() != 0)
      report_other("frames or read results missing at the end");
    if (frames_seen != exp_frames || reads_seen != exp_reads)
      report_other("frame or read count does not match the accepted commands");
    $display("value errors %0d, other errors %0d, frames %0d, reads %0d",
             val_errs, other_errs, frames_seen, reads_seen);
    if (val_errs == 0 && other_errs == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  always @(posedge clk)
  begin
    logic [9:0]         e;
    uart_cmd_pkg::cmd_t exp_c;
    uart_cmd_pkg::cmd_t got_c;
    if (rst_n)
    begin
      if (byte_vld)
      begin
        frames_seen++;
        if (!byte_ok)
          report_other("bad parity or low stop bit on tx");
        if (exp_tx_q.size() == 0)
          report_other("unexpected frame on tx");
        else
          check_byte("tx_byte", exp_tx_q.pop_front(), byte_data);
        if (in_lo)
        begin
          last_lo = byte_data;
          if (gap_clks < GAP * CPB + CPB / 2)
            report_other("gap between write frames too short");
        end
        else
          last_hi = byte_data;
        in_lo = byte_data[7] && !in_lo;
      end
      if (read_vld)
      begin
        reads_seen++;
        if (exp_rd_q.size() == 0)
          report_other("unexpected read_vld pulse");
        else
        begin
          e = exp_rd_q.pop_front();
          if (e[9:8] != 2'(uart_cmd_pkg::RD_TIMEOUT))
            check_byte("read_data", e[7:0], read_data);
          check_status(uart_cmd_pkg::rd_status_e'(e[9:8]),
                       uart_cmd_pkg::rd_status_e'(read_status));
        end
      end
      if (cmd_rdy && !rdy_prev)
      begin
        if (pend_q.size() == 0)
          report_other("command finished with none pending");
        else
        begin
          exp_c = pend_q.pop_front();
          got_c = {last_hi, exp_c.wr ? last_lo : 8'h00};
          if (!exp_c.wr)
            exp_c.data = 8'h00;
          if (read_vld == exp_c.wr)
            report_other("read_vld does not match the command direction");
          check_cmd_done(exp_c, got_c);
        end
      end
      rdy_prev <= cmd_rdy;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles with %0d commands pending", cycles, pend_q.size());
      $display("value errors %0d, other errors %0d, frames %0d, reads %0d",
               val_errs, other_errs, frames_seen, reads_seen);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

//--- bench/uart_periph_model.sv
`timescale 1ns/10ps

module uart_periph_model #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx,
  output logic                  rx,
  input  logic                  knob_vld,
  input  uart_frame_pkg::byte_t knob_data,
  input  logic [15:0]           knob_delay,
  input  logic [1:0]            knob_fault, // 0 none, 1 parity flip, 2 stop low, 3 silent.
  output logic                  byte_vld,
  output uart_frame_pkg::byte_t byte_data,
  output logic                  byte_ok,
  output int                    gap_clks
);

  logic [25:0] knob_q[$];
  logic [25:0] reply_q[$];
  int          cyc = 0;
  int          stop_cyc = 0;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (knob_vld)
      knob_q.push_back({knob_fault, knob_delay, knob_data});
  end

  // decodes frames from the bridge, sampling each bit in its middle.
  initial
  begin
    uart_frame_pkg::byte_t d;
    logic                  par;
    logic                  stp;
    logic [25:0]           k;
    byte_vld = 1'b0;
    wait (rst_n);
    forever
    begin
      @(negedge tx);
      gap_clks <= cyc - stop_cyc;
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      for (int i = 0; i < uart_frame_pkg::DATA_BITS; i++)
      begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        d[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(posedge clk);
      par = tx;
      repeat (CLKS_PER_BIT) @(posedge clk);
      stp = tx;
      stop_cyc = cyc;
      byte_vld  <= 1'b1;
      byte_data <= d;
      byte_ok   <= stp && (par == ^d);
      if (!d[7] && (knob_q.size() > 0))
      begin
        k = knob_q.pop_front();
        if (k[25:24] != 2'd3)
          reply_q.push_back(k);
      end
      @(posedge clk);
      byte_vld <= 1'b0;
    end
  end

  // answers reads on rx, with the fault chosen for this read.
  initial
  begin
    logic [25:0] r;
    rx = 1'b1;
    forever
    begin
      @(posedge clk);
      if (reply_q.size() > 0)
      begin
        r = reply_q.pop_front();
        repeat (r[23:8]) @(posedge clk);
        rx <= 1'b0;
        for (int i = 0; i < uart_frame_pkg::DATA_BITS; i++)
        begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          rx <= r[i];
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        rx <= (^r[7:0]) ^ (r[25:24] == 2'd1);
        repeat (CLKS_PER_BIT) @(posedge clk);
        rx <= (r[25:24] != 2'd2);
        repeat (CLKS_PER_BIT) @(posedge clk);
        rx <= 1'b1;
      end
    end
  end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #10 clk = !clk; // 20 ns period.
  end

  initial
  begin
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- verilog/uart_cmd_bridge.sv
`timescale 1ns/10ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT    = 434,
  parameter int GAP_BITS        = 16,
  parameter int RX_TIMEOUT_BITS = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  input  logic        rx,
  output logic        tx,
  output logic [7:0]  read_data,
  output logic [1:0]  read_status,
  output logic        read_vld
);

  uart_byte_if tx_ch ();
  uart_byte_if rx_ch ();

  uart_cmd_ctrl #(
    .GAP_BITS        (GAP_BITS),
    .RX_TIMEOUT_BITS (RX_TIMEOUT_BITS),
    .CLKS_PER_BIT    (CLKS_PER_BIT)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx_ch       (tx_ch),
    .rx_ch       (rx_ch),
    .read_data   (read_data),
    .read_status (read_status),
    .read_vld    (read_vld)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .ch    (tx_ch),
    .tx    (tx)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .ch    (rx_ch)
  );

endmodule

//--- verilog/uart_cmd_ctrl.sv
`timescale 1ns/10ps

module uart_cmd_ctrl #(
  parameter int GAP_BITS        = 16,
  parameter int RX_TIMEOUT_BITS = 64,
  parameter int CLKS_PER_BIT    = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  uart_byte_if.src                 tx_ch,
  uart_byte_if.sink                rx_ch,
  output uart_frame_pkg::byte_t    read_data,
  output uart_cmd_pkg::rd_status_e read_status,
  output logic                     read_vld
);

  localparam int MAX_BITS = (GAP_BITS > RX_TIMEOUT_BITS) ? GAP_BITS : RX_TIMEOUT_BITS;
  localparam int CLK_W    = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W    = $clog2(MAX_BITS + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_GAP,
    ST_SEND_LO,
    ST_WAIT_RX,
    ST_REPORT
  } state_e;

  state_e             state;
  logic               sent;
  logic [CLK_W-1:0]   clk_cnt;
  logic [BIT_W-1:0]   bit_cnt;
  logic               bit_tick;
  logic               gap_done;
  logic               timeout;
  logic               frame_done;
  uart_cmd_pkg::cmd_t cmd_q;

  // the report cycle carries the result and already takes the next command.
  assign cmd_rdy    = (state == ST_IDLE) || (state == ST_REPORT);
  assign read_vld   = (state == ST_REPORT);
  assign tx_ch.vld  = ((state == ST_SEND_HI) || (state == ST_SEND_LO)) && !sent;
  assign tx_ch.data = (state == ST_SEND_LO) ? cmd_q.data : {cmd_q.wr, cmd_q.addr};
  assign tx_ch.err  = uart_frame_pkg::RX_ERR_NONE;
  assign rx_ch.rdy  = (state == ST_WAIT_RX);
  assign frame_done = sent && tx_ch.rdy; // transmitter idle again after our byte.
  assign bit_tick   = (clk_cnt == CLK_W'(CLKS_PER_BIT - 1));
  assign gap_done   = bit_tick && (bit_cnt == BIT_W'(GAP_BITS - 1));
  assign timeout    = bit_tick && (bit_cnt == BIT_W'(RX_TIMEOUT_BITS - 1));

  // bit-time counter for the write gap and the reply timeout.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if ((state != ST_GAP) && (state != ST_WAIT_RX))
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_tick)
    begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
      clk_cnt <= clk_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      sent  <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE, ST_REPORT:
          state <= cmd_vld ? ST_SEND_HI : ST_IDLE;
        ST_SEND_HI, ST_SEND_LO:
          if (tx_ch.vld && tx_ch.rdy)
            sent <= 1'b1;
          else if (frame_done)
          begin
            sent <= 1'b0;
            if (state == ST_SEND_LO)
              state <= ST_IDLE;
            else
              state <= cmd_q.wr ? ST_GAP : ST_WAIT_RX;
          end
        ST_GAP:
          if (gap_done)
            state <= ST_SEND_LO;
        ST_WAIT_RX:
          if (rx_ch.vld || timeout)
            state <= ST_REPORT;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      cmd_q <= cmd_in;
    if (rx_ch.vld && rx_ch.rdy)
    begin
      read_data <= rx_ch.data;
      case (rx_ch.err)
        uart_frame_pkg::RX_ERR_PARITY: read_status <= uart_cmd_pkg::RD_PARITY;
        uart_frame_pkg::RX_ERR_FRAME:  read_status <= uart_cmd_pkg::RD_FRAME;
        default:                       read_status <= uart_cmd_pkg::RD_OK;
      endcase
    end
    else if ((state == ST_WAIT_RX) && timeout)
    begin
      read_data   <= '0;
      read_status <= uart_cmd_pkg::RD_TIMEOUT;
    end
  end

  // a new command is taken only while the transmitter is idle.
  a_no_accept_while_sending: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx_ch.rdy);

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx,
  uart_byte_if.src ch
);

  localparam int CNT_W     = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W     = $clog2(uart_frame_pkg::FRAME_BITS);
  localparam int HALF_CLKS = CLKS_PER_BIT / 2;

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  active;
  logic [CNT_W-1:0]      cnt;
  logic [IDX_W-1:0]      bit_idx;
  logic                  tick;
  logic                  stop_tick;
  logic                  par_q;
  logic                  par_bad;
  uart_frame_pkg::byte_t shreg;

  // the start bit is checked half a bit in, all later bits a full bit apart.
  assign tick = active && ((bit_idx == '0) ? (cnt == CNT_W'(HALF_CLKS - 1))
                                           : (cnt == CNT_W'(CLKS_PER_BIT - 1)));
  assign stop_tick = tick && (bit_idx == IDX_W'(uart_frame_pkg::FRAME_BITS - 1));
  assign par_bad   = par_q != ((^shreg) ^ !uart_frame_pkg::EVEN_PARITY);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      ch.vld  <= 1'b0;
    end
    else
    begin
      ch.vld <= 1'b0;
      if (!active)
      begin
        cnt     <= '0;
        bit_idx <= '0;
        active  <= rx_prev && !rx_sync; // arm on a falling edge.
      end
      else if (tick)
      begin
        cnt <= '0;
        if ((bit_idx == '0) && rx_sync)
          active <= 1'b0; // start bit gone at mid-bit, so it was a glitch.
        else if (stop_tick)
        begin
          active <= 1'b0;
          ch.vld <= 1'b1;
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tick && (bit_idx != '0) && (bit_idx <= IDX_W'(uart_frame_pkg::DATA_BITS)))
      shreg <= {rx_sync, shreg[uart_frame_pkg::DATA_BITS-1:1]};
    if (tick && (bit_idx == IDX_W'(uart_frame_pkg::DATA_BITS + 1)))
      par_q <= rx_sync;
    if (stop_tick)
    begin
      ch.data <= shreg;
      if (!rx_sync)
        ch.err <= uart_frame_pkg::RX_ERR_FRAME;
      else if (par_bad)
        ch.err <= uart_frame_pkg::RX_ERR_PARITY;
      else
        ch.err <= uart_frame_pkg::RX_ERR_NONE;
    end
  end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n) ch.vld |=> !ch.vld);

  a_clean_frame: assert property (@(posedge clk) disable iff (!rst_n)
    ch.vld && (ch.err == uart_frame_pkg::RX_ERR_NONE)
      |-> (par_q == ((^ch.data) ^ !uart_frame_pkg::EVEN_PARITY)));

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic      clk,
  input  logic      rst_n,
  uart_byte_if.sink ch,
  output logic      tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_frame_pkg::FRAME_BITS);

  logic                                  busy;
  logic [CNT_W-1:0]                      bit_cnt;
  logic [IDX_W-1:0]                      bit_idx;
  logic                                  bit_end;
  logic                                  par_bit;
  logic [uart_frame_pkg::DATA_BITS+1:0]  shreg;

  assign ch.rdy  = !busy;
  assign bit_end = busy && (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign par_bit = (^ch.data) ^ !uart_frame_pkg::EVEN_PARITY;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      if (ch.vld)
      begin
        busy    <= 1'b1;
        tx      <= 1'b0; // start bit goes out right after the handshake.
        bit_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == IDX_W'(uart_frame_pkg::FRAME_BITS - 1))
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  // holds data, parity and stop; the start bit is driven directly.
  always_ff @(posedge clk)
  begin
    if (ch.vld && !busy)
      shreg <= {1'b1, par_bit, ch.data};
    else if (bit_end)
      shreg <= {1'b1, shreg[uart_frame_pkg::DATA_BITS+1:1]};
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) ch.rdy |-> tx);

endmodule

//--- verilog/uart_byte_if.sv
`timescale 1ns/10ps

interface uart_byte_if;

  uart_frame_pkg::byte_t   data;
  logic                    vld;
  logic                    rdy;
  uart_frame_pkg::rx_err_e err;

  modport src (
    output data,
    output vld,
    output err,
    input  rdy
  );

  modport sink (
    input  data,
    input  vld,
    input  err,
    output rdy
  );

endinterface

//--- verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // bit 15 is the direction: 1 writes two bytes, 0 reads one byte back.
  // the high byte on the line is {wr, addr}, the low byte is data.
  typedef struct packed {
    logic                  wr;
    logic [6:0]            addr;
    uart_frame_pkg::byte_t data;
  } cmd_t;

  // status that comes with every read result.
  typedef enum logic [1:0] {
    RD_OK      = 2'd0,
    RD_PARITY  = 2'd1,
    RD_FRAME   = 2'd2,
    RD_TIMEOUT = 2'd3
  } rd_status_e;

endpackage

//--- verilog/uart_frame_pkg.sv
package uart_frame_pkg;

  // one start, DATA_BITS data, one parity and one stop bit per frame.
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;

  // a 1 here selects even parity, a 0 would select odd parity.
  localparam bit EVEN_PARITY = 1'b1;

  typedef logic [DATA_BITS-1:0] byte_t;

  // outcome of one received frame.
  typedef enum logic [1:0] {
    RX_ERR_NONE   = 2'd0,
    RX_ERR_PARITY = 2'd1,
    RX_ERR_FRAME  = 2'd2
  } rx_err_e;

endpackage
